//--- Bender.yml
package:
  name: qspi_cmd

sources:
  - files:
      - hw/raster_cmd_pkg.sv
      - hw/qspi_link_rx.sv
      - hw/buffer_allocator.sv
      - hw/command_fsm.sv
      - hw/reply_serializer.sv
      - hw/qspi_cmd_top.sv
  - target: test
    files:
      - test/tb_qspi_cmd.sv

//--- hw/buffer_allocator.sv
`timescale 1ns/1ps

module buffer_allocator #(
    parameter int CAPACITY = 8192
) (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    alloc_req,
    input  raster_cmd_pkg::count_t  alloc_count,
    output raster_cmd_pkg::buf_id_t alloc_id,
    output raster_cmd_pkg::addr_t   alloc_base,
    output logic                    alloc_fail
);

    localparam int FILL_W = $bits(raster_cmd_pkg::addr_t) + 1;

    // one extra bit so a completely full memory does not wrap to zero
    logic [FILL_W-1:0]       fill;
    logic [FILL_W-1:0]       fill_next;
    raster_cmd_pkg::buf_id_t next_id;

    assign fill_next  = fill + FILL_W'(alloc_count);
    assign alloc_fail = (fill_next > FILL_W'(CAPACITY));
    assign alloc_base = fill[FILL_W-2:0];
    assign alloc_id   = next_id;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            fill    <= '0;
            next_id <= '0;
        end else if (alloc_req && !alloc_fail) begin
            fill    <= fill_next;
            next_id <= next_id + 1'b1;
        end
    end

endmodule

//--- hw/command_fsm.sv
`timescale 1ns/1ps

module command_fsm (
    input  logic                      sck,
    input  logic                      rst,
    input  logic                      nib_valid,
    input  raster_cmd_pkg::nibble_t   nib,
    input  logic                      link_abort,
    input  logic                      reply_done,
    input  raster_cmd_pkg::buf_id_t   vert_alloc_id,
    input  raster_cmd_pkg::addr_t     vert_alloc_base,
    input  logic                      vert_alloc_fail,
    input  raster_cmd_pkg::buf_id_t   tri_alloc_id,
    input  raster_cmd_pkg::addr_t     tri_alloc_base,
    input  logic                      tri_alloc_fail,
    output logic                      vert_alloc_req,
    output logic                      tri_alloc_req,
    output raster_cmd_pkg::count_t    alloc_count,
    output logic                      vert_hdr_valid,
    output raster_cmd_pkg::buf_id_t   vert_id,
    output raster_cmd_pkg::addr_t     vert_base,
    output raster_cmd_pkg::count_t    vert_count,
    output logic                      vert_valid,
    output raster_cmd_pkg::vertex_t   vert_data,
    output logic                      tri_hdr_valid,
    output raster_cmd_pkg::buf_id_t   tri_id,
    output raster_cmd_pkg::addr_t     tri_base,
    output raster_cmd_pkg::count_t    tri_count,
    output logic                      tri_valid,
    output raster_cmd_pkg::triangle_t tri_data,
    output logic                      reply_start,
    output raster_cmd_pkg::buf_id_t   reply_id,
    output raster_cmd_pkg::status_t   reply_status
);

    typedef enum logic [1:0] {
        S_OPCODE,
        S_COUNT,
        S_RECORDS,
        S_AWAIT_REPLY
    } state_t;

    state_t                  state;
    logic                    is_tri;  // command kind of the current buffer
    logic                    oom;     // records swallowed without strobes
    logic [4:0]              nib_cnt;
    raster_cmd_pkg::count_t  rec_cnt;
    raster_cmd_pkg::count_t  count_q;
    raster_cmd_pkg::vertex_t rec_sr;
    raster_cmd_pkg::buf_id_t alloc_id;
    logic                    alloc_fail;
    logic                    alloc_req;
    logic                    count_last;
    logic                    rec_last;

    assign count_last = (nib_cnt == 5'(raster_cmd_pkg::COUNT_NIBBLES - 1));
    assign rec_last   = is_tri ? (nib_cnt == 5'(raster_cmd_pkg::TRIANGLE_NIBBLES - 1))
                               : (nib_cnt == 5'(raster_cmd_pkg::VERTEX_NIBBLES - 1));

    // count including the nibble on the bus
    assign alloc_count = {count_q[$bits(raster_cmd_pkg::count_t)-5:0], nib};
    assign alloc_req   = (state == S_COUNT) && nib_valid && count_last && (alloc_count != '0);

    assign vert_alloc_req = alloc_req && !is_tri;
    assign tri_alloc_req  = alloc_req && is_tri;
    assign alloc_id       = is_tri ? tri_alloc_id : vert_alloc_id;
    assign alloc_fail     = is_tri ? tri_alloc_fail : vert_alloc_fail;

    // record stays put for the strobe cycle
    assign vert_data = rec_sr;
    assign tri_data  = rec_sr[$bits(raster_cmd_pkg::triangle_t)-1:0];

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state          <= S_OPCODE;
            is_tri         <= 1'b0;
            oom            <= 1'b0;
            nib_cnt        <= '0;
            rec_cnt        <= '0;
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
            reply_start    <= 1'b0;
        end else begin
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
            reply_start    <= 1'b0;
            if (link_abort) begin
                state   <= S_OPCODE;  // drop partial command
                nib_cnt <= '0;
            end else begin
                case (state)
                    S_OPCODE: if (nib_valid) begin
                        nib_cnt <= '0;
                        rec_cnt <= '0;
                        is_tri  <= (nib == raster_cmd_pkg::OP_CREATE_TRI);
                        if (nib == raster_cmd_pkg::OP_CREATE_VERT ||
                            nib == raster_cmd_pkg::OP_CREATE_TRI) begin
                            state <= S_COUNT;
                        end else if (nib != raster_cmd_pkg::OP_IDLE) begin
                            reply_start <= 1'b1;  // status-only reply
                            state       <= S_AWAIT_REPLY;
                        end
                    end
                    S_COUNT: if (nib_valid) begin
                        if (!count_last) begin
                            nib_cnt <= nib_cnt + 1'b1;
                        end else begin
                            nib_cnt <= '0;
                            if (alloc_count == '0) begin
                                reply_start <= 1'b1;
                                state       <= S_AWAIT_REPLY;
                            end else begin
                                oom            <= alloc_fail;
                                vert_hdr_valid <= !is_tri && !alloc_fail;
                                tri_hdr_valid  <= is_tri && !alloc_fail;
                                state          <= S_RECORDS;
                            end
                        end
                    end
                    S_RECORDS: if (nib_valid) begin
                        if (!rec_last) begin
                            nib_cnt <= nib_cnt + 1'b1;
                        end else begin
                            nib_cnt    <= '0;
                            vert_valid <= !is_tri && !oom;
                            tri_valid  <= is_tri && !oom;
                            if (rec_cnt == count_q - 1'b1) begin
                                reply_start <= 1'b1;
                                state       <= S_AWAIT_REPLY;
                            end else begin
                                rec_cnt <= rec_cnt + 1'b1;
                            end
                        end
                    end
                    S_AWAIT_REPLY: if (reply_done) begin
                        state <= S_OPCODE;
                    end
                    default: state <= S_OPCODE;
                endcase
            end
        end
    end

    always_ff @(posedge sck) begin
        if (nib_valid && state == S_COUNT) begin
            count_q <= alloc_count;
        end
        if (nib_valid && state == S_RECORDS) begin
            rec_sr <= {rec_sr[$bits(raster_cmd_pkg::vertex_t)-5:0], nib};  // msn first
        end
        if (vert_alloc_req) begin
            vert_id    <= vert_alloc_id;
            vert_base  <= vert_alloc_base;
            vert_count <= alloc_count;
        end
        if (tri_alloc_req) begin
            tri_id    <= tri_alloc_id;
            tri_base  <= tri_alloc_base;
            tri_count <= alloc_count;
        end
        if (nib_valid && state == S_OPCODE) begin
            reply_id     <= '0;
            reply_status <= raster_cmd_pkg::ST_INVALID_OPCODE;
        end
        // on failure the id is the one not handed out
        if (nib_valid && state == S_COUNT && count_last) begin
            reply_id <= alloc_id;
            if (alloc_count == '0) begin
                reply_status <= raster_cmd_pkg::ST_EMPTY_BUFFER;
            end else if (alloc_fail) begin
                reply_status <= raster_cmd_pkg::ST_OUT_OF_MEMORY;
            end else begin
                reply_status <= raster_cmd_pkg::ST_OK;
            end
        end
    end

endmodule

//--- hw/qspi_cmd_top.sv
`timescale 1ns/1ps

module qspi_cmd_top (
    input  logic                      sck,
    input  logic                      rst,
    input  logic                      cs_n,
    input  raster_cmd_pkg::nibble_t   spi_in,
    output raster_cmd_pkg::nibble_t   spi_out,
    output logic                      spi_oe,
    output logic                      vert_hdr_valid,
    output raster_cmd_pkg::buf_id_t   vert_id,
    output raster_cmd_pkg::addr_t     vert_base,
    output raster_cmd_pkg::count_t    vert_count,
    output logic                      vert_valid,
    output raster_cmd_pkg::vertex_t   vert_data,
    output logic                      tri_hdr_valid,
    output raster_cmd_pkg::buf_id_t   tri_id,
    output raster_cmd_pkg::addr_t     tri_base,
    output raster_cmd_pkg::count_t    tri_count,
    output logic                      tri_valid,
    output raster_cmd_pkg::triangle_t tri_data
);

    logic                    nib_valid;
    raster_cmd_pkg::nibble_t nib;
    logic                    link_abort;
    logic                    reply_busy;
    logic                    reply_done;
    logic                    reply_start;
    raster_cmd_pkg::buf_id_t reply_id;
    raster_cmd_pkg::status_t reply_status;

    logic                    vert_alloc_req;
    logic                    tri_alloc_req;
    raster_cmd_pkg::count_t  alloc_count;
    raster_cmd_pkg::buf_id_t vert_alloc_id;
    raster_cmd_pkg::addr_t   vert_alloc_base;
    logic                    vert_alloc_fail;
    raster_cmd_pkg::buf_id_t tri_alloc_id;
    raster_cmd_pkg::addr_t   tri_alloc_base;
    logic                    tri_alloc_fail;

    qspi_link_rx link_i (
        .sck        (sck),
        .rst        (rst),
        .cs_n       (cs_n),
        .spi_in     (spi_in),
        .reply_busy (reply_busy),
        .nib_valid  (nib_valid),
        .nib        (nib),
        .link_abort (link_abort)
    );

    command_fsm cmd_i (
        .sck             (sck),
        .rst             (rst),
        .nib_valid       (nib_valid),
        .nib             (nib),
        .link_abort      (link_abort),
        .reply_done      (reply_done),
        .vert_alloc_id   (vert_alloc_id),
        .vert_alloc_base (vert_alloc_base),
        .vert_alloc_fail (vert_alloc_fail),
        .tri_alloc_id    (tri_alloc_id),
        .tri_alloc_base  (tri_alloc_base),
        .tri_alloc_fail  (tri_alloc_fail),
        .vert_alloc_req  (vert_alloc_req),
        .tri_alloc_req   (tri_alloc_req),
        .alloc_count     (alloc_count),
        .vert_hdr_valid  (vert_hdr_valid),
        .vert_id         (vert_id),
        .vert_base       (vert_base),
        .vert_count      (vert_count),
        .vert_valid      (vert_valid),
        .vert_data       (vert_data),
        .tri_hdr_valid   (tri_hdr_valid),
        .tri_id          (tri_id),
        .tri_base        (tri_base),
        .tri_count       (tri_count),
        .tri_valid       (tri_valid),
        .tri_data        (tri_data),
        .reply_start     (reply_start),
        .reply_id        (reply_id),
        .reply_status    (reply_status)
    );

    buffer_allocator #(.CAPACITY(raster_cmd_pkg::VERT_CAPACITY)) vert_alloc_i (
        .sck         (sck),
        .rst         (rst),
        .alloc_req   (vert_alloc_req),
        .alloc_count (alloc_count),
        .alloc_id    (vert_alloc_id),
        .alloc_base  (vert_alloc_base),
        .alloc_fail  (vert_alloc_fail)
    );

    buffer_allocator #(.CAPACITY(raster_cmd_pkg::TRI_CAPACITY)) tri_alloc_i (
        .sck         (sck),
        .rst         (rst),
        .alloc_req   (tri_alloc_req),
        .alloc_count (alloc_count),
        .alloc_id    (tri_alloc_id),
        .alloc_base  (tri_alloc_base),
        .alloc_fail  (tri_alloc_fail)
    );

    reply_serializer reply_i (
        .sck          (sck),
        .rst          (rst),
        .reply_start  (reply_start),
        .reply_id     (reply_id),
        .reply_status (reply_status),
        .spi_out      (spi_out),
        .spi_oe       (spi_oe),
        .reply_busy   (reply_busy),
        .reply_done   (reply_done)
    );

endmodule

//--- hw/qspi_link_rx.sv
`timescale 1ns/1ps

module qspi_link_rx (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    cs_n,
    input  raster_cmd_pkg::nibble_t spi_in,
    input  logic                    reply_busy,
    output logic                    nib_valid,
    output raster_cmd_pkg::nibble_t nib,
    output logic                    link_abort
);

    localparam int SETTLE_W = $clog2(raster_cmd_pkg::SETTLE_CYCLES + 1);

    logic [SETTLE_W-1:0] settle_cnt;
    logic                settled;
    logic                cs_n_q;

    assign settled = (settle_cnt == SETTLE_W'(raster_cmd_pkg::SETTLE_CYCLES));

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            settle_cnt <= '0;
            cs_n_q     <= 1'b1;
        end else begin
            cs_n_q <= cs_n;
            if (cs_n) begin
                settle_cnt <= '0;  // restart on every deselect
            end else if (!settled) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    // reply owns the bus while busy
    assign nib_valid  = settled && !cs_n && !reply_busy;
    assign nib        = spi_in;
    assign link_abort = cs_n && !cs_n_q;  // rising cs_n

endmodule

//--- hw/raster_cmd_pkg.sv
package raster_cmd_pkg;

    // transfer sizes in nibbles
    localparam int COUNT_NIBBLES    = 3;
    localparam int VERTEX_NIBBLES   = 27;
    localparam int TRIANGLE_NIBBLES = 9;

    // memory sizes in words
    localparam int VERT_CAPACITY = 8192;
    localparam int TRI_CAPACITY  = 8192;

    localparam int SETTLE_CYCLES     = 8;  // junk nibbles after cs_n falls
    localparam int TURNAROUND_CYCLES = 2;

    typedef logic [3:0]                      nibble_t;
    typedef logic [4*COUNT_NIBBLES-1:0]      count_t;
    typedef logic [12:0]                     addr_t;
    typedef logic [7:0]                      buf_id_t;
    typedef logic [4*VERTEX_NIBBLES-1:0]     vertex_t;  // 3x32 position, 3x4 attributes
    typedef logic [3*$bits(count_t)-1:0]     triangle_t; // three vertex indices
    typedef logic [3:0]                      opcode_t;
    typedef logic [3:0]                      status_t;

    localparam opcode_t OP_IDLE        = 4'd0;
    localparam opcode_t OP_CREATE_VERT = 4'd1;
    localparam opcode_t OP_CREATE_TRI  = 4'd2;

    localparam status_t ST_OK             = 4'd0;
    localparam status_t ST_INVALID_OPCODE = 4'd1;
    localparam status_t ST_OUT_OF_MEMORY  = 4'd2;
    localparam status_t ST_EMPTY_BUFFER   = 4'd3;

endpackage

//--- hw/reply_serializer.sv
`timescale 1ns/1ps

module reply_serializer (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    reply_start,
    input  raster_cmd_pkg::buf_id_t reply_id,
    input  raster_cmd_pkg::status_t reply_status,
    output raster_cmd_pkg::nibble_t spi_out,
    output logic                    spi_oe,
    output logic                    reply_busy,
    output logic                    reply_done
);

    typedef enum logic [2:0] {
        R_IDLE,
        R_TURN,
        R_ID_HI,
        R_ID_LO,
        R_STATUS
    } rstate_t;

    rstate_t                 state;
    logic [1:0]              turn_cnt;
    raster_cmd_pkg::buf_id_t id_q;
    raster_cmd_pkg::status_t status_q;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state    <= R_IDLE;
            turn_cnt <= '0;
        end else begin
            case (state)
                R_IDLE: if (reply_start) begin
                    state    <= R_TURN;
                    turn_cnt <= '0;
                end
                R_TURN: begin
                    // host releases the bus here
                    if (turn_cnt == 2'(raster_cmd_pkg::TURNAROUND_CYCLES - 1)) begin
                        state <= R_ID_HI;
                    end else begin
                        turn_cnt <= turn_cnt + 1'b1;
                    end
                end
                R_ID_HI:  state <= R_ID_LO;
                R_ID_LO:  state <= R_STATUS;
                R_STATUS: state <= R_IDLE;
                default:  state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge sck) begin
        if (state == R_IDLE && reply_start) begin
            id_q     <= reply_id;
            status_q <= reply_status;
        end
    end

    always_comb begin
        case (state)
            R_ID_HI:  spi_out = id_q[7:4];
            R_ID_LO:  spi_out = id_q[3:0];
            R_STATUS: spi_out = status_q;
            default:  spi_out = '0;
        endcase
    end

    assign spi_oe     = (state == R_ID_HI) || (state == R_ID_LO) || (state == R_STATUS);
    assign reply_busy = reply_start || (state != R_IDLE);
    assign reply_done = (state == R_STATUS);  // with the last nibble

endmodule

//--- test/cmd_patterns.txt
# opcode count exp_id exp_base exp_status, all decimal
# status 0 ok, 1 invalid opcode, 2 out of memory, 3 empty buffer
1 3 0 0 0
2 2 0 0 0
0 0 0 0 0
1 4095 1 3 0
2 3 1 2 0
1 4095 2 4098 2
1 5 2 4098 0
7 0 0 0 1
2 0 2 5 3
1 0 3 4103 3
15 0 0 0 1
2 1 2 5 0

//--- test/tb_qspi_cmd.sv
`timescale 1ns/1ps

module tb_qspi_cmd;

    logic                      sck;
    logic                      rst;
    logic                      cs_n;
    raster_cmd_pkg::nibble_t   spi_in;
    raster_cmd_pkg::nibble_t   spi_out;
    logic                      spi_oe;
    logic                      vert_hdr_valid;
    raster_cmd_pkg::buf_id_t   vert_id;
    raster_cmd_pkg::addr_t     vert_base;
    raster_cmd_pkg::count_t    vert_count;
    logic                      vert_valid;
    raster_cmd_pkg::vertex_t   vert_data;
    logic                      tri_hdr_valid;
    raster_cmd_pkg::buf_id_t   tri_id;
    raster_cmd_pkg::addr_t     tri_base;
    raster_cmd_pkg::count_t    tri_count;
    logic                      tri_valid;
    raster_cmd_pkg::triangle_t tri_data;

    integer                    seed;
    int                        errors;
    int                        checks;
    longint                    limit_ns;
    int                        vhdr_seen;
    int                        thdr_seen;
    int                        vrec_seen;
    int                        trec_seen;
    raster_cmd_pkg::buf_id_t   exp_id;
    raster_cmd_pkg::addr_t     exp_base;
    raster_cmd_pkg::count_t    exp_count;
    raster_cmd_pkg::vertex_t   vert_q[$];
    raster_cmd_pkg::triangle_t tri_q[$];
    int                        pat_op[$];
    int                        pat_cnt[$];
    int                        pat_id[$];
    int                        pat_base[$];
    int                        pat_status[$];

    qspi_cmd_top dut_i (.*);

    initial begin
        sck = 1'b0;
        forever #2 sck = ~sck;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic drive_nibble(input raster_cmd_pkg::nibble_t n);
        @(posedge sck);
        #1 spi_in = n;
    endtask

    // host side of the reply starting at the edge that samples the last nibble
    task automatic expect_reply(input raster_cmd_pkg::buf_id_t id,
                                input raster_cmd_pkg::status_t status);
        @(posedge sck);
        #1 spi_in = '0;
        for (int k = 0; k < 1 + raster_cmd_pkg::TURNAROUND_CYCLES; k++) begin
            @(negedge sck);
            check_value("spi_oe", spi_oe, 1'b0);  // reply_start plus turnaround
        end
        @(negedge sck);
        check_value("spi_oe", spi_oe, 1'b1);
        check_value("spi_out id high", spi_out, id[7:4]);
        @(negedge sck);
        check_value("spi_oe", spi_oe, 1'b1);
        check_value("spi_out id low", spi_out, id[3:0]);
        @(negedge sck);
        check_value("spi_oe", spi_oe, 1'b1);
        check_value("spi_out status", spi_out, status);
        @(negedge sck);
        check_value("spi_oe", spi_oe, 1'b0);
    endtask

    task automatic run_command(input int op, input int cnt, input int id, input int base,
                               input int status);
        int                     rec_nibbles;
        logic                   create;
        logic                   ok;
        logic [127:0]           rec;
        raster_cmd_pkg::count_t c;
        create = (op == raster_cmd_pkg::OP_CREATE_VERT) || (op == raster_cmd_pkg::OP_CREATE_TRI);
        ok = create && (status == raster_cmd_pkg::ST_OK);
        rec_nibbles = (op == raster_cmd_pkg::OP_CREATE_TRI) ? raster_cmd_pkg::TRIANGLE_NIBBLES
                                                            : raster_cmd_pkg::VERTEX_NIBBLES;
        c = cnt;
        exp_id = id;
        exp_base = base;
        exp_count = c;
        vhdr_seen = 0;
        thdr_seen = 0;
        vrec_seen = 0;
        trec_seen = 0;
        @(posedge sck);
        #1 cs_n = 1'b0;
        spi_in = $random(seed);
        for (int k = 1; k < raster_cmd_pkg::SETTLE_CYCLES; k++) begin
            drive_nibble($random(seed));  // junk while the link settles
        end
        drive_nibble(op);
        if (create) begin
            for (int k = raster_cmd_pkg::COUNT_NIBBLES - 1; k >= 0; k--) begin
                drive_nibble(c[4*k +: 4]);
            end
            for (int r = 0; r < cnt; r++) begin
                rec = {$random(seed), $random(seed), $random(seed), $random(seed)};
                if (ok && op == raster_cmd_pkg::OP_CREATE_VERT) begin
                    vert_q.push_back(rec[$bits(raster_cmd_pkg::vertex_t)-1:0]);
                end else if (ok) begin
                    tri_q.push_back(rec[$bits(raster_cmd_pkg::triangle_t)-1:0]);
                end
                for (int j = rec_nibbles - 1; j >= 0; j--) begin
                    drive_nibble(rec[4*j +: 4]);
                end
            end
        end
        if (op == raster_cmd_pkg::OP_IDLE) begin
            @(posedge sck);
            #1 spi_in = '0;
            repeat (8) begin
                @(negedge sck);
                check_value("spi_oe", spi_oe, 1'b0);  // idle gets no reply
            end
        end else begin
            expect_reply(id, status);
        end
        @(posedge sck);
        #1 cs_n = 1'b1;
        repeat (2) @(posedge sck);
        check_value("vert_hdr_valid pulses", vhdr_seen, (ok && !op[1]) ? 1 : 0);
        check_value("vert_valid pulses", vrec_seen, (ok && !op[1]) ? cnt : 0);
        check_value("tri_hdr_valid pulses", thdr_seen, (ok && op[1]) ? 1 : 0);
        check_value("tri_valid pulses", trec_seen, (ok && op[1]) ? cnt : 0);
    endtask

    // strobes are sampled mid cycle
    always @(negedge sck) begin
        if (!rst) begin
            if (vert_hdr_valid) begin
                vhdr_seen++;
                check_value("vert_id", vert_id, exp_id);
                check_value("vert_base", vert_base, exp_base);
                check_value("vert_count", vert_count, exp_count);
            end
            if (tri_hdr_valid) begin
                thdr_seen++;
                check_value("tri_id", tri_id, exp_id);
                check_value("tri_base", tri_base, exp_base);
                check_value("tri_count", tri_count, exp_count);
            end
            if (vert_valid) begin
                vrec_seen++;
                if (vert_q.size() == 0) begin
                    errors++;
                    $display("vertex record strobe at %0t with no record outstanding", $time);
                end else begin
                    check_value("vert_data", vert_data, vert_q.pop_front());
                end
            end
            if (tri_valid) begin
                trec_seen++;
                if (tri_q.size() == 0) begin
                    errors++;
                    $display("triangle record strobe at %0t with no record outstanding", $time);
                end else begin
                    check_value("tri_data", tri_data, tri_q.pop_front());
                end
            end
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout after %0d ns, the command stream did not complete", limit_ns);
        $display("Test failures found");
        $finish;
    end

    initial begin
        string  line;
        int     fd;
        int     op;
        int     cnt;
        int     id;
        int     base;
        int     status;
        longint cycles;
        rst = 1'b1;
        cs_n = 1'b1;
        spi_in = '0;
        seed = 60563;
        errors = 0;
        checks = 0;
        fd = $fopen("test/cmd_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open test/cmd_patterns.txt, no commands were run");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.getc(0) != "#" &&
                    $sscanf(line, "%d %d %d %d %d", op, cnt, id, base, status) == 5) begin
                    pat_op.push_back(op);
                    pat_cnt.push_back(cnt);
                    pat_id.push_back(id);
                    pat_base.push_back(base);
                    pat_status.push_back(status);
                end
            end
            $fclose(fd);
        end
        cycles = 8;
        foreach (pat_op[i]) begin
            cycles += raster_cmd_pkg::SETTLE_CYCLES + 1 + raster_cmd_pkg::TURNAROUND_CYCLES + 15;
            if (pat_op[i] == raster_cmd_pkg::OP_CREATE_VERT) begin
                cycles += raster_cmd_pkg::COUNT_NIBBLES
                          + pat_cnt[i] * raster_cmd_pkg::VERTEX_NIBBLES;
            end else if (pat_op[i] == raster_cmd_pkg::OP_CREATE_TRI) begin
                cycles += raster_cmd_pkg::COUNT_NIBBLES
                          + pat_cnt[i] * raster_cmd_pkg::TRIANGLE_NIBBLES;
            end
        end
        limit_ns = cycles * 4 * 2;
        repeat (8) @(posedge sck);
        #1 rst = 1'b0;
        foreach (pat_op[i]) begin
            run_command(pat_op[i], pat_cnt[i], pat_id[i], pat_base[i], pat_status[i]);
        end
        $display("commands: %0d, checks: %0d, errors: %0d", pat_op.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/raster_cmd_pkg.sv
hw/qspi_link_rx.sv
hw/buffer_allocator.sv
hw/command_fsm.sv
hw/reply_serializer.sv
hw/qspi_cmd_top.sv
test/tb_qspi_cmd.sv
